// ==== common/div_pkg.sv ====
/*
 * Divider package
 * Shared types of the RV32 execute-stage divider: operand width,
 * M-extension divide operations, the pipeline slot contents and
 * the states of the division sequencer
 */
package div_pkg;

	// Default datapath width of the core, RV32
	localparam int XLEN = 32;

	// One operand or result as it travels through the EXE stage
	typedef logic [XLEN-1:0] word_t;

	// Divide operation as decoded in ID
	// Bit 0 set selects unsigned operands
	// Bit 1 set returns the remainder instead of the quotient
	typedef enum logic [1:0] {
		DIV  = 2'd0,
		DIVU = 2'd1,
		REM  = 2'd2,
		REMU = 2'd3
	} div_op_t;

	// Contents of one pipeline slot, used for both the ID and the EXE slot
	// Valid low marks a bubble, the other fields are then don't care
	typedef struct packed {
		logic    valid;
		div_op_t op;
		word_t   opa;
		word_t   opb;
	} div_req_t;

	// Sequencer states
	// RESET is left one cycle after reset
	// WAIT looks for a valid operation in the EXE slot
	// DIVIDING runs until the core reports done
	// DONE presents the result for a single cycle and releases the stall
	typedef enum logic [1:0] {
		RESET    = 2'd0,
		WAIT     = 2'd1,
		DIVIDING = 2'd2,
		DONE     = 2'd3
	} div_state_t;

endpackage

// ==== divider/div_core.sv ====
`timescale 1ns/1ps
/*
 * Radix-2 restoring divider core
 * Divides one operand pair per start pulse, signed or unsigned.
 * Magnitudes are divided over XLEN shift-subtract steps, then one
 * more cycle applies the result signs. Divide-by-zero and signed
 * overflow fall out of the datapath with the RISC-V results.
 */
module div_core import div_pkg::*; #(
	parameter int XLEN = div_pkg::XLEN
) (
	input  logic  CLK,
	input  logic  nrst,
	input  logic  start,
	input  logic  is_signed,
	input  word_t dividend,
	input  word_t divisor,
	output logic  busy,
	output logic  done,
	output word_t quotient,
	output word_t remainder
);

	// Counter wide enough to hold XLEN itself
	localparam int CW = $clog2(XLEN + 1);

	// Iteration control
	logic          busy_q;
	logic          fix_q;
	logic          done_q;
	logic [CW-1:0] cnt_q;

	// Datapath state, quo_q starts as the dividend magnitude and is
	// shifted out at the top while the quotient bits enter at the bottom
	word_t rem_q;
	word_t quo_q;
	word_t dvs_q;
	logic  q_neg_q;
	logic  r_neg_q;

	// Operand decode
	logic  a_neg;
	logic  b_neg;
	word_t a_mag;
	word_t b_mag;

	// One restoring step
	logic [XLEN:0] r_shift;
	logic [XLEN:0] r_diff;
	logic          q_bit;

	// Cycle type
	logic load;
	logic step;

	assign load = start & ~busy_q;
	assign step = busy_q & ~fix_q;

	// Sign and magnitude of both operands
	// The most negative value maps onto itself, which is the correct
	// unsigned magnitude 2^(XLEN-1)
	always_comb begin
		a_neg = is_signed & dividend[XLEN-1];
		b_neg = is_signed & divisor[XLEN-1];
		a_mag = a_neg ? -dividend : dividend;
		b_mag = b_neg ? -divisor : divisor;
	end

	// Shift the next dividend bit into the partial remainder and try
	// the subtraction, a borrow out means the divisor did not fit
	always_comb begin
		r_shift = {rem_q, quo_q[XLEN-1]};
		r_diff  = r_shift - {1'b0, dvs_q};
		q_bit   = ~r_diff[XLEN];
	end

	// Control sequence, load then XLEN steps then one sign-fix cycle
	// done is registered so it lines up with the final result registers
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			busy_q <= 1'b0;
			fix_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (load) begin
				busy_q <= 1'b1;
				cnt_q  <= CW'(XLEN);
			end else if (step) begin
				cnt_q <= cnt_q - CW'(1);
				// Last step this cycle, next cycle fixes the signs
				if (cnt_q == CW'(1)) begin
					fix_q <= 1'b1;
				end
			end else if (fix_q) begin
				fix_q  <= 1'b0;
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	// Datapath
	// With a zero divisor every step succeeds, so the quotient becomes all
	// ones and the remainder the dividend magnitude. The quotient sign is
	// suppressed in that case and the remainder keeps the dividend sign,
	// which gives back the dividend
	// For the most negative value over minus one the magnitudes give
	// 2^(XLEN-1) rem 0 and equal signs, so the dividend comes back
	always_ff @(posedge CLK) begin
		if (load) begin
			rem_q   <= '0;
			quo_q   <= a_mag;
			dvs_q   <= b_mag;
			q_neg_q <= (a_neg ^ b_neg) & (divisor != '0);
			r_neg_q <= a_neg;
		end else if (step) begin
			rem_q <= q_bit ? r_diff[XLEN-1:0] : r_shift[XLEN-1:0];
			quo_q <= {quo_q[XLEN-2:0], q_bit};
		end else if (fix_q) begin
			// Remainder takes the sign of the dividend
			quo_q <= q_neg_q ? -quo_q : quo_q;
			rem_q <= r_neg_q ? -rem_q : rem_q;
		end
	end

	assign busy      = busy_q;
	assign done      = done_q;
	assign quotient  = quo_q;
	assign remainder = rem_q;

endmodule

// ==== divider/divider_unit.sv ====
`timescale 1ns/1ps
/*
 * Divider sequencing unit
 * Watches the EXE slot for a divide operation, starts the core and
 * stalls the pipeline until the result is ready. The quotient or the
 * remainder is registered as the result and flagged for one cycle.
 */
module divider_unit import div_pkg::*; #(
	parameter int XLEN = div_pkg::XLEN
) (
	input  logic     CLK,
	input  logic     nrst,
	input  logic     load_hazard,
	input  div_req_t exe_req,
	output logic     div_running,
	output word_t    result,
	output logic     result_valid
);

	// Sequencer state
	div_state_t div_state;
	div_state_t div_nstate;

	// High when a valid operation sits in EXE with no load hazard
	logic start_go;

	// Core interface
	logic  core_done;
	word_t core_quo;
	word_t core_rem;

	// Start is only possible in WAIT, so this is a single-cycle pulse
	// The core has always finished by the time the sequencer is back in WAIT
	assign start_go = (div_state == WAIT) & exe_req.valid & ~load_hazard;

	// Operands come straight from the EXE slot, which is frozen by the
	// stall while the core works
	div_core #(
		.XLEN(XLEN)
	) u_core (
		.CLK      (CLK),
		.nrst     (nrst),
		.start    (start_go),
		.is_signed(~exe_req.op[0]),
		.dividend (exe_req.opa),
		.divisor  (exe_req.opb),
		.busy     (),
		.done     (core_done),
		.quotient (core_quo),
		.remainder(core_rem)
	);

	// State register
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			div_state <= RESET;
		end else begin
			div_state <= div_nstate;
		end
	end

	// Next state
	always_comb begin
		div_nstate = div_state;
		case (div_state)
			RESET: div_nstate = WAIT;
			WAIT: begin
				if (start_go) begin
					div_nstate = DIVIDING;
				end
			end
			DIVIDING: begin
				if (core_done) begin
					div_nstate = DONE;
				end
			end
			DONE: div_nstate = WAIT;
			default: div_nstate = RESET;
		endcase
	end

	// div_running rises in the WAIT cycle that starts the core, one cycle
	// ahead of DIVIDING, so the front of the pipeline freezes at once
	// It drops in DONE, which lets the issue stage take the next operation
	always_comb begin
		div_running = 1'b0;
		case (div_state)
			WAIT:     div_running = start_go;
			DIVIDING: div_running = 1'b1;
			default:  div_running = 1'b0;
		endcase
	end

	// Result is captured as the core reports done, so it is stable
	// throughout the DONE cycle
	// Op bit 1 picks the remainder
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			result <= '0;
		end else if (div_state == DIVIDING && core_done) begin
			result <= exe_req.op[1] ? core_rem : core_quo;
		end
	end

	// One result per operation, DONE lasts exactly one cycle
	assign result_valid = (div_state == DONE);

endmodule

// ==== verilog/div_issue_stage.sv ====
`timescale 1ns/1ps
/*
 * ID to EXE issue register
 * Holds the operation in the EXE slot and forms the pipeline stall
 * from the divider and the load hazard.
 */
module div_issue_stage import div_pkg::*; #(
	parameter int XLEN = div_pkg::XLEN
) (
	input  logic     CLK,
	input  logic     nrst,
	input  logic     load_hazard,
	input  logic     div_running,
	input  div_req_t id_req,
	output div_req_t exe_req,
	output logic     stall
);

	// Register input, either the new ID operation or the held EXE slot
	div_req_t exe_nxt;

	// The only point where the divider and the load hazard meet
	// While either is high the pipeline front must not advance, and the
	// pipeline keeps id_req steady for as long as this stays high
	assign stall = div_running | load_hazard;

	// An ID operation moves into EXE on the first edge with stall low
	// A divide in progress keeps its operands and op in the EXE slot, which
	// the sequencer reads until the result has been captured
	always_comb begin
		if (stall) begin
			exe_nxt = exe_req;
		end else begin
			exe_nxt = id_req;
		end
	end

	// EXE slot register
	// Reset only marks the slot empty
	// Op and operands of an empty slot are never looked at
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			exe_req.valid <= 1'b0;
		end else begin
			exe_req <= exe_nxt;
		end
	end

endmodule

// ==== verilog/div_subsystem.sv ====
`timescale 1ns/1ps
/*
 * Divider subsystem of the execute stage
 * Issue register and divider sequencing unit for DIV, DIVU, REM and
 * REMU. Exposes the stall towards the front of the pipeline.
 */
module div_subsystem import div_pkg::*; #(
	parameter int XLEN = div_pkg::XLEN
) (
	input  logic     CLK,
	input  logic     nrst,
	input  logic     load_hazard,
	input  div_req_t id_req,
	output logic     stall,
	output word_t    result,
	output logic     result_valid
);

	// Operation currently in the EXE slot
	div_req_t exe_req;

	// High while the divider holds the pipeline
	logic div_running;

	// ID to EXE register and stall generation
	div_issue_stage #(
		.XLEN(XLEN)
	) u_issue (
		.CLK        (CLK),
		.nrst       (nrst),
		.load_hazard(load_hazard),
		.div_running(div_running),
		.id_req     (id_req),
		.exe_req    (exe_req),
		.stall      (stall)
	);

	// Sequencer with the restoring divider core
	// It sees the same load hazard, which holds off the start
	divider_unit #(
		.XLEN(XLEN)
	) u_div (
		.CLK         (CLK),
		.nrst        (nrst),
		.load_hazard (load_hazard),
		.exe_req     (exe_req),
		.div_running (div_running),
		.result      (result),
		.result_valid(result_valid)
	);

endmodule

// ==== bench/div_subsystem_sva.sv ====
`timescale 1ns/1ps
/*
 * Protocol checks of the divider subsystem
 * Bound into div_subsystem, watches the result flag, the stall
 * and the transfer from the ID slot into the EXE slot
 */
module div_subsystem_sva import div_pkg::*; (
	input logic       CLK,
	input logic       nrst,
	input logic       stall,
	input logic       result_valid,
	input div_req_t   id_req,
	input div_req_t   exe_req,
	input div_state_t div_state
);

	// Number of failed assertions
	int fail_count = 0;

	// A result is flagged for one cycle only
	result_one_cycle: assert property (@(posedge CLK) disable iff (!nrst)
		result_valid |=> !result_valid)
	else begin
		$error("result_valid stayed high for more than one cycle");
		fail_count++;
	end

	result_quiet_in_reset: assert property (@(posedge CLK)
		!nrst |=> !result_valid)
	else begin
		$error("result_valid high during reset");
		fail_count++;
	end

	// The core never runs without the pipeline frozen
	stall_while_dividing: assert property (@(posedge CLK) disable iff (!nrst)
		(div_state == DIVIDING) |-> stall)
	else begin
		$error("stall low while the divider is in DIVIDING");
		fail_count++;
	end

	// ID may change only in the first stalled cycle, when it has just advanced
	id_held_in_stall: assert property (@(posedge CLK) disable iff (!nrst)
		(stall && $past(stall)) |-> $stable(id_req))
	else begin
		$error("id_req changed while the pipeline was stalled");
		fail_count++;
	end

	exe_takes_id: assert property (@(posedge CLK) disable iff (!nrst)
		!stall |=> (exe_req == $past(id_req)))
	else begin
		$error("exe_req differs from the ID slot it took");
		fail_count++;
	end

	exe_holds: assert property (@(posedge CLK) disable iff (!nrst)
		stall |=> $stable(exe_req))
	else begin
		$error("exe_req changed under stall");
		fail_count++;
	end

endmodule

bind div_subsystem div_subsystem_sva u_sva (
	.CLK         (CLK),
	.nrst        (nrst),
	.stall       (stall),
	.result_valid(result_valid),
	.id_req      (id_req),
	.exe_req     (exe_req),
	.div_state   (u_div.div_state)
);

// ==== bench/tb_div_subsystem.sv ====
`timescale 1ns/1ps
/*
 * Testbench of the divider subsystem
 * Pushes DIV, DIVU, REM and REMU through the ID slot and compares every
 * result with a RISC-V reference model, one report line per test
 */
module tb_div_subsystem import div_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	// Cycles allowed for one division, well above XLEN steps plus overhead
	localparam int TIMEOUT = 4 * XLEN + 20;
	localparam word_t MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic     CLK = 1'b0;
	logic     nrst;
	logic     load_hazard;
	div_req_t id_req;
	logic     stall;
	word_t    result;
	logic     result_valid;

	int   seed = 32'hbbdc_683b;
	logic timed_out = 1'b0;
	int   test_errors = 0;
	int   total_errors = 0;
	int   checks = 0;
	int   tests_run = 0;
	int   tests_failed = 0;

	// Expected results in issue order, and results as they leave the DUT
	word_t exp_q[$];
	word_t got_q[$];

	div_op_t ops[4] = '{DIV, DIVU, REM, REMU};

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	div_subsystem #(
		.XLEN(XLEN)
	) u_dut (
		.CLK         (CLK),
		.nrst        (nrst),
		.load_hazard (load_hazard),
		.id_req      (id_req),
		.stall       (stall),
		.result      (result),
		.result_valid(result_valid)
	);

	// Outputs only move on the rising edge, so the falling edge sees them settled
	always @(negedge CLK) begin
		if (nrst && result_valid) begin
			got_q.push_back(result);
		end
	end

	// RISC-V M-extension divide semantics
	// A zero divisor yields all ones and the dividend as remainder
	// The most negative value over minus one returns the dividend with remainder zero
	function automatic word_t ref_result(input div_op_t op, input word_t a, input word_t b);
		word_t q;
		word_t r;
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (op == DIVU || op == REMU) begin
			q = a / b;
			r = a % b;
		end else if (a == MOST_NEG && b == '1) begin
			q = a;
			r = '0;
		end else begin
			// Signed % in SystemVerilog keeps the dividend sign, as RISC-V does
			q = word_t'($signed(a) / $signed(b));
			r = word_t'($signed(a) % $signed(b));
		end
		return (op == REM || op == REMU) ? r : q;
	endfunction

	task automatic check_word(input string name, input word_t exp_val, input word_t got_val);
		checks++;
		assert (got_val === exp_val) else begin
			test_errors++;
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp_val, got_val);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic got_val);
		checks++;
		assert (got_val === exp_val) else begin
			test_errors++;
			$display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp_val, got_val);
		end
	endtask

	// Present one slot in ID and hold it until an edge with stall low takes it
	task automatic issue_op(input logic valid, input div_op_t op, input word_t a, input word_t b);
		int       waited;
		div_req_t req;
		waited = 0;
		req.valid = valid;
		req.op = op;
		req.opa = a;
		req.opb = b;
		@(negedge CLK);
		id_req = req;
		#1;
		while (stall && !timed_out) begin
			waited++;
			if (waited > TIMEOUT) begin
				timed_out = 1'b1;
				$display("Timeout at %0t, stall never fell to take the next ID slot", $time);
			end else begin
				@(negedge CLK);
				#1;
			end
		end
		if (!timed_out) begin
			@(posedge CLK);
			#1;
			// A valid operation stalls the pipeline in the very cycle it lands in EXE
			if (valid) begin
				exp_q.push_back(ref_result(op, a, b));
				check_flag("stall", 1'b1, stall);
			end
		end
	endtask

	task automatic clear_id();
		@(negedge CLK);
		id_req = '0;
	endtask

	task automatic wait_results(input int n);
		int waited;
		waited = 0;
		while (got_q.size() < n && !timed_out) begin
			@(negedge CLK);
			#1;
			waited++;
			if (waited > n * TIMEOUT) begin
				timed_out = 1'b1;
				$display("Timeout at %0t, only %0d of %0d results arrived", $time, got_q.size(), n);
			end
		end
	endtask

	// One result per operation, in the order they were issued
	task automatic compare_results();
		word_t exp_val;
		word_t got_val;
		check_word("result count", word_t'(exp_q.size()), word_t'(got_q.size()));
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			exp_val = exp_q.pop_front();
			got_val = got_q.pop_front();
			check_word("result", exp_val, got_val);
		end
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic run_op(input div_op_t op, input word_t a, input word_t b);
		issue_op(1'b1, op, a, b);
		clear_id();
		wait_results(1);
		compare_results();
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (test_errors == 0 && !timed_out) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		word_t a;
		word_t b;
		int    hold;
		nrst = 1'b0;
		load_hazard = 1'b0;
		id_req = '0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		nrst = 1'b1;
		#1;
		check_flag("stall", 1'b0, stall);
		check_flag("result_valid", 1'b0, result_valid);
		check_word("result", '0, result);
		report_test("reset");

		for (int i = 0; i < 200; i++) begin
			a = $random(seed);
			b = $random(seed);
			// Narrow the divisor now and then so the quotients get large
			b = word_t'($signed(b) >>> (i % 24));
			for (int k = 0; k < 4; k++) begin
				run_op(ops[k], a, b);
			end
		end
		report_test("random operands");

		for (int k = 0; k < 4; k++) begin
			run_op(ops[k], $random(seed), '0);
			run_op(ops[k], MOST_NEG, '0);
		end
		run_op(DIV, MOST_NEG, '1);
		run_op(REM, MOST_NEG, '1);
		report_test("divide by zero and overflow");

		// Each new slot waits in ID while the one before it divides
		for (int k = 0; k < 6; k++) begin
			a = $random(seed);
			b = word_t'($random(seed)) >> (k * 4);
			issue_op(1'b1, ops[k % 4], a, b);
		end
		clear_id();
		wait_results(6);
		// Extra result_valid pulses would land in this window
		repeat (TIMEOUT) @(negedge CLK);
		#1;
		compare_results();
		report_test("back to back");

		for (int t = 0; t < 4; t++) begin
			hold = 1 + int'($unsigned($random(seed)) % 8);
			issue_op(1'b1, ops[t], $random(seed), $random(seed));
			@(negedge CLK);
			load_hazard = 1'b1;
			id_req = '0;
			repeat (hold) begin
				@(negedge CLK);
				#1;
				check_flag("stall", 1'b1, stall);
				check_flag("u_div.div_state is WAIT", 1'b1, u_dut.u_div.div_state == WAIT);
			end
			check_word("result count under load_hazard", '0, word_t'(got_q.size()));
			@(negedge CLK);
			load_hazard = 1'b0;
			wait_results(1);
			compare_results();
		end
		report_test("load hazard");

		issue_op(1'b0, REM, $random(seed), $random(seed));
		repeat (2 * XLEN) begin
			@(negedge CLK);
			#1;
			check_flag("stall", 1'b0, stall);
		end
		check_word("result count", '0, word_t'(got_q.size()));
		report_test("invalid ID slot");

		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, total_errors, u_dut.u_sva.fail_count);
		if (tests_failed == 0 && u_dut.u_sva.fail_count == 0 && !timed_out) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
common/div_pkg.sv
divider/div_core.sv
divider/divider_unit.sv
verilog/div_issue_stage.sv
verilog/div_subsystem.sv
bench/div_subsystem_sva.sv
bench/tb_div_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the divider subsystem testbench with Verilator and run it
# The run passes only when the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
	--top-module tb_div_subsystem \
	-Mdir obj_dir \
	-f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# Let assertion failures be counted instead of stopping at the first one
out=$(./obj_dir/Vtb_div_subsystem +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
